//--- src/vec_ctrl_pkg.sv
package vec_ctrl_pkg;

    localparam int INSTR_W   = 32;
    localparam int XLEN      = 32;
    localparam int RF_ADDR_W = 8;   // vector register file address
    localparam int PC_W      = 6;   // word index, 64-word program
    localparam int ITR_W     = 12;

    // major opcodes
    localparam logic [6:0] OPC_VLOAD  = 7'h07;
    localparam logic [6:0] OPC_VSTORE = 7'h27;
    localparam logic [6:0] OPC_OPV    = 7'h57;
    localparam logic [6:0] OPC_STREAM = 7'h7F;  // custom streaming extension
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_OPIMM  = 7'h13;
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_CSR    = 7'h03;

    // funct3 / funct7 selectors
    localparam logic [2:0] F3_VMACC    = 3'h0;
    localparam logic [2:0] F3_VMV      = 3'h5;
    localparam logic [2:0] F3_VSETIVLI = 3'h7;
    localparam logic [2:0] F3_BNE      = 3'h1;
    localparam logic [2:0] F3_ADD      = 3'h0;  // addi and add
    localparam logic [6:0] F7_ADD      = 7'h00;

    localparam logic [INSTR_W-1:0] WFI_WORD  = 32'h1050_0073;
    localparam logic [11:0]        CSR_CYCLE = 12'hC00;

    // vector command codes on cmd_op
    localparam logic [2:0] CMD_VLE     = 3'd0;
    localparam logic [2:0] CMD_VSE     = 3'd1;
    localparam logic [2:0] CMD_VMACC   = 3'd2;
    localparam logic [2:0] CMD_VMV     = 3'd3;
    localparam logic [2:0] CMD_VSTREAM = 3'd4;

    // one instruction word, scalar layout or vsetivli layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [1:0]  top2;
            logic [11:0] itr;    // instr 29:18
            logic [2:0]  vlen;   // instr 17:15
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } cfg;
    } instr_word_u;

endpackage

//--- src/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             imem_wr_en,
    input  logic [vec_ctrl_pkg::PC_W-1:0]    imem_wr_addr,
    input  logic [vec_ctrl_pkg::INSTR_W-1:0] imem_wr_data,
    input  logic                             is_vect,
    input  logic                             is_wfi,
    input  logic                             vec_done,
    input  logic                             branch_taken,
    input  logic [vec_ctrl_pkg::PC_W-1:0]    branch_offset,
    output logic [vec_ctrl_pkg::INSTR_W-1:0] instr,
    output logic                             instr_valid,
    output logic                             running
);

    logic [vec_ctrl_pkg::INSTR_W-1:0] imem [2**vec_ctrl_pkg::PC_W];
    logic [vec_ctrl_pkg::PC_W-1:0]    pc;
    logic                             waiting;   // vector command outstanding

    // host loads the program only while halted
    always_ff @(posedge clk) begin
        if (imem_wr_en && !running) begin
            imem[imem_wr_addr] <= imem_wr_data;
        end
    end

    assign instr       = imem[pc];  // async read at pc
    assign instr_valid = running && !waiting;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            running <= 1'b0;
            waiting <= 1'b0;
        end else if (start) begin
            pc      <= '0;
            running <= 1'b1;
            waiting <= 1'b0;
        end else if (instr_valid) begin
            if (is_wfi) begin
                running <= 1'b0;    // pc stays on the wfi
            end else if (is_vect) begin
                waiting <= 1'b1;
                pc      <= pc + 1'b1;
            end else if (branch_taken) begin
                pc <= pc + branch_offset;  // wraps within the 64-word program
            end else begin
                pc <= pc + 1'b1;
            end
        end else if (waiting && vec_done) begin
            waiting <= 1'b0;   // next instruction decodes in the following cycle
        end
    end

endmodule

//--- src/isa_decoder.sv
`timescale 1ns/1ps

module isa_decoder (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [vec_ctrl_pkg::INSTR_W-1:0]   instr,
    input  logic                               instr_valid,
    output logic                               is_vle,
    output logic                               is_vse,
    output logic                               is_vmacc,
    output logic                               is_vmv,
    output logic                               is_vstream,
    output logic                               is_vect,
    output logic                               is_wfi,
    output logic                               is_lui,
    output logic                               is_addi,
    output logic                               is_add,
    output logic                               is_csr,
    output logic                               is_bne,
    output logic [4:0]                         rs1,
    output logic [4:0]                         rs2,
    output logic [4:0]                         rd,
    output logic [vec_ctrl_pkg::XLEN-1:0]      imm,
    output logic [11:0]                        branch_immediate,
    output logic [vec_ctrl_pkg::ITR_W-1:0]     itr,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] vr_addr,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] vw_addr
);

    vec_ctrl_pkg::instr_word_u iw;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       is_vsetivli;
    logic [2:0] vlen_q;    // chunk size exponent from vsetivli
    logic [4:0] vs2;
    logic [4:0] vd;

    // index scaled to the chunk base in the vector register file
    function automatic logic [vec_ctrl_pkg::RF_ADDR_W-1:0] scale_addr(
        input logic [4:0] idx,
        input logic [2:0] vlen
    );
        logic [4:0] mask;
        logic [2:0] shamt;
        logic [vec_ctrl_pkg::RF_ADDR_W-1:0] wide;
        if (vlen >= 3'd4) begin
            mask = 5'h1f;   // all five index bits
        end else begin
            mask = 5'((6'd2 << vlen) - 6'd1);
        end
        shamt = 3'(vec_ctrl_pkg::RF_ADDR_W - 1) - vlen;
        wide  = vec_ctrl_pkg::RF_ADDR_W'(idx & mask);
        return wide << shamt;
    endfunction

    assign iw  = instr;
    assign opc = iw.s.opcode;
    assign f3  = iw.s.funct3;

    // vector class
    assign is_vle      = (opc == vec_ctrl_pkg::OPC_VLOAD);
    assign is_vse      = (opc == vec_ctrl_pkg::OPC_VSTORE);
    assign is_vmacc    = (opc == vec_ctrl_pkg::OPC_OPV) && (f3 == vec_ctrl_pkg::F3_VMACC);
    assign is_vmv      = (opc == vec_ctrl_pkg::OPC_OPV) && (f3 == vec_ctrl_pkg::F3_VMV);
    assign is_vstream  = (opc == vec_ctrl_pkg::OPC_STREAM);
    assign is_vsetivli = (iw.cfg.opcode == vec_ctrl_pkg::OPC_OPV)
                      && (iw.cfg.funct3 == vec_ctrl_pkg::F3_VSETIVLI);
    assign is_vect     = is_vle | is_vse | is_vmacc | is_vmv | is_vstream;

    // scalar class
    assign is_lui  = (opc == vec_ctrl_pkg::OPC_LUI);
    assign is_addi = (opc == vec_ctrl_pkg::OPC_OPIMM) && (f3 == vec_ctrl_pkg::F3_ADD);
    assign is_add  = (opc == vec_ctrl_pkg::OPC_OP) && (f3 == vec_ctrl_pkg::F3_ADD)
                  && (iw.s.funct7 == vec_ctrl_pkg::F7_ADD);
    assign is_csr  = (opc == vec_ctrl_pkg::OPC_CSR)
                  && ({iw.s.funct7, iw.s.rs2} == vec_ctrl_pkg::CSR_CYCLE);
    assign is_bne  = (opc == vec_ctrl_pkg::OPC_BRANCH) && (f3 == vec_ctrl_pkg::F3_BNE);
    assign is_wfi  = (instr == vec_ctrl_pkg::WFI_WORD);

    assign rs1 = iw.s.rs1;
    assign rs2 = iw.s.rs2;
    assign rd  = iw.s.rd;

    // half-word units, bit 0 of the B-type offset is implicit
    assign branch_immediate = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        if (is_addi) begin
            imm = {{(vec_ctrl_pkg::XLEN-12){iw.s.funct7[6]}}, iw.s.funct7, iw.s.rs2};
        end else begin
            imm = {instr[31:12], {(vec_ctrl_pkg::XLEN-20){1'b0}}};  // lui
        end
    end

    // VLEN only moves on an issued vsetivli
    always_ff @(posedge clk) begin
        if (rst) begin
            vlen_q <= 3'd0;
        end else if (instr_valid && is_vsetivli) begin
            vlen_q <= iw.cfg.vlen;
        end
    end

    assign itr = iw.cfg.itr;

    assign vs2 = is_vse ? iw.s.rd : iw.s.rs2;   // vse carries the source in the rd slot
    assign vd  = iw.s.rd;

    assign vr_addr = scale_addr(vs2, vlen_q);
    assign vw_addr = scale_addr(vd, vlen_q);

endmodule

//--- src/scalar_unit.sv
`timescale 1ns/1ps

module scalar_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_valid,
    input  logic                            is_lui,
    input  logic                            is_addi,
    input  logic                            is_add,
    input  logic                            is_csr,
    input  logic                            is_bne,
    input  logic [4:0]                      rs1,
    input  logic [4:0]                      rs2,
    input  logic [4:0]                      rd,
    input  logic [vec_ctrl_pkg::XLEN-1:0]   imm,
    input  logic [11:0]                     branch_immediate,
    output logic                            wb_valid,
    output logic [4:0]                      wb_rd,
    output logic [vec_ctrl_pkg::XLEN-1:0]   wb_data,
    output logic                            branch_taken,
    output logic [vec_ctrl_pkg::PC_W-1:0]   branch_offset
);

    logic [vec_ctrl_pkg::XLEN-1:0] regs [32];
    logic [vec_ctrl_pkg::XLEN-1:0] rs1_val;
    logic [vec_ctrl_pkg::XLEN-1:0] rs2_val;
    logic [vec_ctrl_pkg::XLEN-1:0] cycle_cnt;
    logic                          writes_rd;

    // x0 is hardwired
    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // counts issued cycles only
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else if (instr_valid) begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    always_comb begin
        if (is_lui) begin
            wb_data = imm;
        end else if (is_addi) begin
            wb_data = rs1_val + imm;
        end else if (is_add) begin
            wb_data = rs1_val + rs2_val;
        end else begin
            wb_data = cycle_cnt;   // csr read of cycle
        end
    end

    assign writes_rd = is_lui | is_addi | is_add | is_csr;
    assign wb_valid  = instr_valid && writes_rd && (rd != 5'd0);
    assign wb_rd     = rd;

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            regs[rd] <= wb_data;
        end
    end

    // bne only; offset converted from half-words to words
    assign branch_taken  = instr_valid && is_bne && (rs1_val != rs2_val);
    assign branch_offset = branch_immediate[vec_ctrl_pkg::PC_W:1];

endmodule

//--- src/vec_cmd_out.sv
`timescale 1ns/1ps

module vec_cmd_out (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               instr_valid,
    input  logic                               is_vle,
    input  logic                               is_vse,
    input  logic                               is_vmacc,
    input  logic                               is_vmv,
    input  logic                               is_vstream,
    input  logic                               is_wfi,
    input  logic [vec_ctrl_pkg::ITR_W-1:0]     itr,
    input  logic [vec_ctrl_pkg::RF_ADDR_W-1:0] vr_addr,
    input  logic [vec_ctrl_pkg::RF_ADDR_W-1:0] vw_addr,
    input  logic                               done_steady,
    input  logic                               start,
    output logic                               cmd_valid,
    output logic [2:0]                         cmd_op,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] cmd_vr_addr,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] cmd_vw_addr,
    output logic [vec_ctrl_pkg::ITR_W-1:0]     cmd_itr,
    output logic                               ap_done
);

    logic       vec_issue;
    logic [2:0] op_enc;
    logic       wfi_halted;   // wfi already reached in this run
    logic       done_given;

    assign vec_issue = instr_valid && (is_vle | is_vse | is_vmacc | is_vmv | is_vstream);

    always_comb begin
        if (is_vle)        op_enc = vec_ctrl_pkg::CMD_VLE;
        else if (is_vse)   op_enc = vec_ctrl_pkg::CMD_VSE;
        else if (is_vmacc) op_enc = vec_ctrl_pkg::CMD_VMACC;
        else if (is_vmv)   op_enc = vec_ctrl_pkg::CMD_VMV;
        else               op_enc = vec_ctrl_pkg::CMD_VSTREAM;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= vec_issue;   // one-cycle strobe
        end
    end

    // command payload
    always_ff @(posedge clk) begin
        if (vec_issue) begin
            cmd_op      <= op_enc;
            cmd_vr_addr <= vr_addr;
            cmd_vw_addr <= vw_addr;
            cmd_itr     <= itr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wfi_halted <= 1'b0;
            done_given <= 1'b0;
        end else if (start) begin
            wfi_halted <= 1'b0;
            done_given <= 1'b0;
        end else begin
            if (instr_valid && is_wfi) wfi_halted <= 1'b1;
            if (ap_done) done_given <= 1'b1;
        end
    end

    assign ap_done = ((instr_valid && is_wfi) || wfi_halted) && done_steady && !done_given;

endmodule

//--- src/vec_ctrl_top.sv
`timescale 1ns/1ps

module vec_ctrl_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               imem_wr_en,
    input  logic [vec_ctrl_pkg::PC_W-1:0]      imem_wr_addr,
    input  logic [vec_ctrl_pkg::INSTR_W-1:0]   imem_wr_data,
    input  logic                               start,
    input  logic                               vec_done,
    input  logic                               done_steady,
    output logic                               cmd_valid,
    output logic [2:0]                         cmd_op,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] cmd_vr_addr,
    output logic [vec_ctrl_pkg::RF_ADDR_W-1:0] cmd_vw_addr,
    output logic [vec_ctrl_pkg::ITR_W-1:0]     cmd_itr,
    output logic                               wb_valid,
    output logic [4:0]                         wb_rd,
    output logic [vec_ctrl_pkg::XLEN-1:0]      wb_data,
    output logic                               ap_done,
    output logic                               running
);

    logic [vec_ctrl_pkg::INSTR_W-1:0]   instr;
    logic                               instr_valid;
    logic                               is_vle, is_vse, is_vmacc, is_vmv, is_vstream;
    logic                               is_vect, is_wfi;
    logic                               is_lui, is_addi, is_add, is_csr, is_bne;
    logic [4:0]                         rs1, rs2, rd;
    logic [vec_ctrl_pkg::XLEN-1:0]      imm;
    logic [11:0]                        branch_immediate;
    logic [vec_ctrl_pkg::ITR_W-1:0]     itr;
    logic [vec_ctrl_pkg::RF_ADDR_W-1:0] vr_addr, vw_addr;
    logic                               branch_taken;
    logic [vec_ctrl_pkg::PC_W-1:0]      branch_offset;

    // program memory and pc
    instr_fetch u_fetch (
        .clk, .rst, .start, .imem_wr_en, .imem_wr_addr, .imem_wr_data,
        .is_vect, .is_wfi, .vec_done, .branch_taken, .branch_offset,
        .instr, .instr_valid, .running
    );

    isa_decoder u_dec (
        .clk, .rst, .instr, .instr_valid,
        .is_vle, .is_vse, .is_vmacc, .is_vmv, .is_vstream, .is_vect, .is_wfi,
        .is_lui, .is_addi, .is_add, .is_csr, .is_bne,
        .rs1, .rs2, .rd, .imm, .branch_immediate, .itr, .vr_addr, .vw_addr
    );

    scalar_unit u_scalar (
        .clk, .rst, .instr_valid, .is_lui, .is_addi, .is_add, .is_csr, .is_bne,
        .rs1, .rs2, .rd, .imm, .branch_immediate,
        .wb_valid, .wb_rd, .wb_data, .branch_taken, .branch_offset
    );

    // command strobes toward the vector datapath
    vec_cmd_out u_cmd (
        .clk, .rst, .instr_valid,
        .is_vle, .is_vse, .is_vmacc, .is_vmv, .is_vstream, .is_wfi,
        .itr, .vr_addr, .vw_addr, .done_steady, .start,
        .cmd_valid, .cmd_op, .cmd_vr_addr, .cmd_vw_addr, .cmd_itr, .ap_done
    );

endmodule

//--- sim/tb_vec_ctrl.sv
`timescale 1ns/1ps

module tb_vec_ctrl;

    localparam logic [31:0] WFI       = 32'h1050_0073;
    localparam int          RUN_LIMIT = 400;

    logic        clk;
    logic        rst;
    logic        imem_wr_en;
    logic [5:0]  imem_wr_addr;
    logic [31:0] imem_wr_data;
    logic        start;
    logic        vec_done;
    logic        done_steady;
    logic        cmd_valid;
    logic [2:0]  cmd_op;
    logic [7:0]  cmd_vr_addr;
    logic [7:0]  cmd_vw_addr;
    logic [11:0] cmd_itr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        ap_done;
    logic        running;

    logic [31:0] prog [$];
    logic [63:0] got_q [$];   // writebacks and commands in arrival order
    logic [63:0] exp_q [$];
    logic [31:0] rng_state;
    logic        pending;     // command out, vec_done not given yet
    int          done_delay;
    int          ap_cnt;
    int          err_cnt;
    int          other_cnt;

    vec_ctrl_top DUT (
        .clk, .rst, .imem_wr_en, .imem_wr_addr, .imem_wr_data,
        .start, .vec_done, .done_steady,
        .cmd_valid, .cmd_op, .cmd_vr_addr, .cmd_vw_addr, .cmd_itr,
        .wb_valid, .wb_rd, .wb_data, .ap_done, .running
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
        return {upper, rd, 7'h37};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic logic [31:0] csr_word(input logic [4:0] rd);
        return {12'hC00, 5'd0, 3'b010, rd, 7'h03};
    endfunction

    // B-type, offset in bytes
    function automatic logic [31:0] bne_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'h63};
    endfunction

    // register index kept to min(vlen+1, 5) bits, then moved up by 7-vlen
    function automatic logic [7:0] chunk_addr(input logic [4:0] idx, input int vlen);
        int bits;
        int kept;
        bits = (vlen + 1 < 5) ? vlen + 1 : 5;
        kept = int'(idx) % (1 << bits);
        return 8'((kept << (7 - vlen)) % 256);
    endfunction

    function automatic void expect_wb(input logic [4:0] rd, input logic [31:0] data);
        exp_q.push_back({27'd0, rd, data});
    endfunction

    function automatic void expect_cmd(input logic [2:0] op, input logic [7:0] vr,
                                       input logic [7:0] vw, input logic [11:0] itr);
        exp_q.push_back({1'b1, 32'd0, op, vr, vw, itr});
    endfunction

    task automatic flag_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        err_cnt++;
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
    endtask

    // pulses vec_done a few cycles after each command strobe
    task automatic answer_vec_cmd();
        if (vec_done) begin
            vec_done = 1'b0;
            pending  = 1'b0;
        end else if (cmd_valid) begin
            pending    = 1'b1;
            done_delay = 3;
        end else if (pending) begin
            done_delay--;
            if (done_delay == 0) begin
                vec_done = 1'b1;
            end
        end
    endtask

    task automatic watch_cycle();
        @(negedge clk);
        answer_vec_cmd();
        if (wb_valid) begin
            if (pending) begin
                other_cnt++;
                $display("writeback to x%0d appeared before vec_done", wb_rd);
            end
            got_q.push_back({27'd0, wb_rd, wb_data});
        end
        if (cmd_valid) begin
            got_q.push_back({1'b1, 32'd0, cmd_op, cmd_vr_addr, cmd_vw_addr, cmd_itr});
        end
        if (ap_done) begin
            ap_cnt++;
        end
    endtask

    // load prog, pulse start and follow the run until wfi halts it
    task automatic run_program(input string name);
        int n;
        got_q.delete();
        ap_cnt = 0;
        foreach (prog[i]) begin
            @(negedge clk);
            imem_wr_en   = 1'b1;
            imem_wr_addr = 6'(i);
            imem_wr_data = prog[i];
        end
        @(negedge clk);
        imem_wr_en = 1'b0;
        start      = 1'b1;
        watch_cycle();
        start = 1'b0;
        n = 0;
        while (running && n < RUN_LIMIT) begin
            watch_cycle();
            n++;
        end
        if (running) begin
            other_cnt++;
            $display("%s: timeout, program did not reach wfi in %0d cycles", name, RUN_LIMIT);
        end
    endtask

    task automatic check_events(input string name);
        if (got_q.size() != exp_q.size()) begin
            flag_mismatch({name, " event count"}, 64'(exp_q.size()), 64'(got_q.size()));
        end else begin
            foreach (exp_q[i]) begin
                if (got_q[i] !== exp_q[i]) begin
                    flag_mismatch(name, exp_q[i], got_q[i]);
                end
            end
        end
    endtask

    task automatic scalar_arith();
        logic [31:0] r;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [11:0] neg_imm;
        r       = next_rand();
        neg_imm = 12'hF9C;   // -100
        x1      = {r[31:12], 12'h000};
        x2      = x1 + {{20{neg_imm[11]}}, neg_imm};
        prog.delete();
        exp_q.delete();
        prog.push_back(lui_word(5'd1, r[31:12]));
        prog.push_back(addi_word(5'd2, 5'd1, neg_imm));
        prog.push_back(addi_word(5'd3, 5'd0, 12'd1234));
        prog.push_back(add_word(5'd4, 5'd2, 5'd3));
        prog.push_back(WFI);
        expect_wb(5'd1, x1);
        expect_wb(5'd2, x2);
        expect_wb(5'd3, 32'd1234);
        expect_wb(5'd4, x2 + 32'd1234);
        run_program("scalar_arith");
        check_events("scalar_arith");
    endtask

    task automatic branch_loop();
        prog.delete();
        exp_q.delete();
        prog.push_back(addi_word(5'd5, 5'd0, 12'd5));
        prog.push_back(addi_word(5'd5, 5'd5, 12'hFFF));   // count down
        prog.push_back(bne_word(5'd5, 5'd0, 13'h1FFC));   // back one word
        prog.push_back(addi_word(5'd6, 5'd0, 12'd77));
        prog.push_back(WFI);
        expect_wb(5'd5, 32'd5);
        for (int k = 4; k >= 0; k--) begin
            expect_wb(5'd5, 32'(k));
        end
        expect_wb(5'd6, 32'd77);
        run_program("branch_loop");
        check_events("branch_loop");
    endtask

    task automatic cycle_csr();
        int          n;
        logic [31:0] delta;
        n = 4;
        prog.delete();
        prog.push_back(csr_word(5'd7));
        for (int i = 0; i < n; i++) begin
            prog.push_back(addi_word(5'd8, 5'd0, 12'(i)));
        end
        prog.push_back(csr_word(5'd9));
        prog.push_back(WFI);
        run_program("cycle_csr");
        if (got_q.size() != n + 2) begin
            flag_mismatch("cycle_csr writebacks", 64'(n + 2), 64'(got_q.size()));
        end else begin
            delta = got_q[n + 1][31:0] - got_q[0][31:0];
            if (delta !== 32'(n + 1)) begin
                flag_mismatch("cycle_csr", 64'(n + 1), 64'(delta));
            end
        end
    endtask

    task automatic vector_cmds();
        int          vlens [4] = '{0, 2, 4, 7};
        int          order [5] = '{0, 2, 1, 3, 4};   // vle, vmacc, vse, vmv, vstreamout
        logic [31:0] r;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  vs2;
        prog.delete();
        exp_q.delete();
        foreach (vlens[k]) begin
            r = next_rand();
            prog.push_back({r[31:18], 3'(vlens[k]), 3'b111, r[11:7], 7'h57});  // vsetivli
            foreach (order[j]) begin
                r  = next_rand();
                f3 = r[14:12];
                case (order[j])
                    0: opc = 7'h07;
                    1: opc = 7'h27;
                    4: opc = 7'h7F;
                    default: opc = 7'h57;
                endcase
                if (order[j] == 2) begin
                    f3 = 3'd0;
                end else if (order[j] == 3) begin
                    f3 = 3'd5;
                end
                w   = {r[31:15], f3, r[11:7], opc};
                vs2 = (order[j] == 1) ? w[11:7] : w[24:20];   // vse reads from the rd slot
                prog.push_back(w);
                expect_cmd(3'(order[j]), chunk_addr(vs2, vlens[k]),
                           chunk_addr(w[11:7], vlens[k]), w[29:18]);
            end
            prog.push_back(addi_word(5'd10, 5'd0, 12'(k + 1)));
            expect_wb(5'd10, 32'(k + 1));
        end
        prog.push_back(WFI);
        run_program("vector_cmds");
        check_events("vector_cmds");
    endtask

    task automatic wfi_done();
        prog.delete();
        exp_q.delete();
        prog.push_back(addi_word(5'd11, 5'd0, 12'd1));
        prog.push_back(WFI);
        expect_wb(5'd11, 32'd1);
        done_steady = 1'b0;
        run_program("wfi_done");
        check_events("wfi_done");
        repeat (3) watch_cycle();
        if (running !== 1'b0) begin
            flag_mismatch("wfi_done running", 64'd0, 64'(running));
        end
        if (ap_cnt != 0) begin
            flag_mismatch("wfi_done ap_done while not steady", 64'd0, 64'(ap_cnt));
        end
        done_steady = 1'b1;
        ap_cnt      = 0;
        // ap_done follows done_steady combinationally, so look just after the drive
        repeat (6) begin
            #1;
            if (ap_done) begin
                ap_cnt++;
            end
            @(negedge clk);
        end
        done_steady = 1'b0;
        if (ap_cnt != 1) begin
            flag_mismatch("wfi_done ap_done pulses", 64'd1, 64'(ap_cnt));
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        vec_done     = 1'b0;
        done_steady  = 1'b0;
        pending      = 1'b0;
        done_delay   = 0;
        ap_cnt       = 0;
        err_cnt      = 0;
        other_cnt    = 0;
        rng_state    = 32'h3168a64a;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        scalar_arith();
        branch_loop();
        cycle_csr();
        vector_cmds();
        wfi_done();
        $display("%0d value mismatches, %0d other failures", err_cnt, other_cnt);
        if (err_cnt == 0 && other_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sim.f
src/vec_ctrl_pkg.sv
src/instr_fetch.sv
src/isa_decoder.sv
src/scalar_unit.sv
src/vec_cmd_out.sv
src/vec_ctrl_top.sv
sim/tb_vec_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing -Wno-fatal --top-module tb_vec_ctrl -f sim.f -o tb_vec_ctrl \
    && ./obj_dir/tb_vec_ctrl | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
